//--- design/pe_switch_pkg.sv
package pe_switch_pkg;

    // switch geometry
    localparam int n_pe = 4;
    localparam int n_src = n_pe + 1;
    localparam int src_w = $clog2(n_src);

    localparam int dest_w = 3;
    localparam logic [dest_w-1:0] dest_egress = 3'd4;

    localparam int data_w = 32;
    localparam int field_w = 4;
    localparam int operand_w = data_w - 2 * field_w;

    // pe opcodes, anything else acts as pass
    localparam logic [field_w-1:0] op_pass = 4'd0;
    localparam logic [field_w-1:0] op_add_id = 4'd1;
    localparam logic [field_w-1:0] op_invert = 4'd2;
    localparam logic [field_w-1:0] op_shift = 4'd3;

    // one stream word, seen as a pe command or as plain bits
    typedef union packed {
        struct packed {
            logic [field_w-1:0] op;
            // only the low dest_w bits route
            logic [field_w-1:0] next_dest;
            logic [operand_w-1:0] operand;
        } cmd;
        logic [data_w-1:0] raw;
    } flit_t;

endpackage

//--- design/dest_arbiter.sv
`timescale 1ns/1ps

module dest_arbiter import pe_switch_pkg::*; (
    input  logic             CLK,
    input  logic             RST_N,
    input  logic [n_src-1:0] req,
    input  logic             advance,
    output logic [n_src-1:0] grant
);

    logic [src_w-1:0] ptr;
    logic [src_w-1:0] win;
    logic             found;

    // first requester at or after ptr, wrapping
    always_comb begin
        logic [src_w:0] idx;
        grant = '0;
        win = ptr;
        found = 1'b0;
        for (int i = 0; i < n_src; i++) begin
            idx = {1'b0, ptr} + (src_w + 1)'(i);
            if (idx >= (src_w + 1)'(n_src)) begin
                idx = idx - (src_w + 1)'(n_src);
            end
            if (!found && req[idx[src_w-1:0]]) begin
                found = 1'b1;
                win = idx[src_w-1:0];
            end
        end
        if (found) begin
            grant[win] = 1'b1;
        end
    end

    // pointer moves past the winner only when a word is taken
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            ptr <= '0;
        end else if (advance && found) begin
            if (win == src_w'(n_src - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= win + 1'b1;
            end
        end
    end

endmodule

//--- design/pe_crossbar.sv
`timescale 1ns/1ps

module pe_crossbar import pe_switch_pkg::*; (
    input  logic                           CLK,
    input  logic                           RST_N,

    // ingress
    input  logic                           in_valid,
    output logic                           in_ready,
    input  flit_t                          in_data,
    input  logic [dest_w-1:0]              in_dest,

    // toward the pes
    output logic [n_pe-1:0]                pe_in_valid,
    input  logic [n_pe-1:0]                pe_in_ready,
    output flit_t [n_pe-1:0]               pe_in_data,

    // from the pes
    input  logic [n_pe-1:0]                pe_out_valid,
    output logic [n_pe-1:0]                pe_out_ready,
    input  flit_t [n_pe-1:0]               pe_out_data,
    input  logic [n_pe-1:0][dest_w-1:0]    pe_out_dest,

    // egress
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [data_w-1:0]              out_data
);

    // source 0 is ingress, source k+1 is pe k
    logic [n_src-1:0]              src_valid;
    logic [n_src-1:0]              src_ready;
    logic [n_src-1:0]              src_drop;
    flit_t [n_src-1:0]             src_data;
    logic [n_src-1:0][dest_w-1:0]  src_dest;

    // one output slot per destination, egress is the top one
    logic [dest_egress:0]              slot_valid;
    logic [dest_egress:0]              slot_ready;
    logic [dest_egress:0]              slot_free;
    logic [dest_egress:0]              slot_load;
    flit_t [dest_egress:0]             slot_data;
    flit_t [dest_egress:0]             slot_next;

    logic [dest_egress:0][n_src-1:0]   req;
    logic [dest_egress:0][n_src-1:0]   grant;

    assign src_valid = {pe_out_valid, in_valid};
    assign src_data = {pe_out_data, in_data};
    assign src_dest = {pe_out_dest, in_dest};

    assign in_ready = src_ready[0];
    assign pe_out_ready = src_ready[n_src-1:1];

    assign slot_ready = {out_ready, pe_in_ready};
    // empty or draining this cycle
    assign slot_free = ~slot_valid | slot_ready;

    always_comb begin
        for (int s = 0; s < n_src; s++) begin
            src_drop[s] = src_valid[s] && (src_dest[s] > dest_egress);
            for (int d = 0; d <= int'(dest_egress); d++) begin
                req[d][s] = src_valid[s] && (src_dest[s] == dest_w'(d)) && slot_free[d];
            end
        end
    end

    for (genvar d = 0; d <= int'(dest_egress); d++) begin : g_dest
        dest_arbiter dest_arbiter_inst (
            .CLK     (CLK),
            .RST_N   (RST_N),
            .req     (req[d]),
            .advance (slot_free[d]),
            .grant   (grant[d])
        );
    end

    // a grant is the transfer, out of range words are swallowed
    always_comb begin
        for (int s = 0; s < n_src; s++) begin
            src_ready[s] = src_drop[s];
            for (int d = 0; d <= int'(dest_egress); d++) begin
                src_ready[s] = src_ready[s] | grant[d][s];
            end
        end
    end

    always_comb begin
        for (int d = 0; d <= int'(dest_egress); d++) begin
            slot_load[d] = |grant[d];
            slot_next[d] = '0;
            for (int s = 0; s < n_src; s++) begin
                if (grant[d][s]) begin
                    slot_next[d] = src_data[s];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            slot_valid <= '0;
        end else begin
            for (int d = 0; d <= int'(dest_egress); d++) begin
                if (slot_load[d]) begin
                    slot_valid[d] <= 1'b1;
                end else if (slot_ready[d]) begin
                    slot_valid[d] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int d = 0; d <= int'(dest_egress); d++) begin
            if (slot_load[d]) begin
                slot_data[d] <= slot_next[d];
            end
        end
    end

    assign pe_in_valid = slot_valid[n_pe-1:0];
    assign pe_in_data = slot_data[n_pe-1:0];

    // egress sees plain bits
    assign out_valid = slot_valid[dest_egress];
    assign out_data = slot_data[dest_egress].raw;

endmodule

//--- design/pe_core.sv
`timescale 1ns/1ps

module pe_core import pe_switch_pkg::*; #(
    parameter int pe_id = 0
) (
    input  logic              CLK,
    input  logic              RST_N,

    input  logic              in_valid,
    output logic              in_ready,
    input  flit_t             in_data,

    output logic              out_valid,
    input  logic              out_ready,
    output flit_t             out_data,
    output logic [dest_w-1:0] out_dest
);

    logic                 accept;
    logic [operand_w-1:0] result;
    flit_t                next_word;

    // take a new command only into an empty register, so pe ready
    // never loops back through the crossbar grants of a pe chain
    assign in_ready = ~out_valid;
    assign accept = in_valid & in_ready;

    always_comb begin
        case (in_data.cmd.op)
            op_add_id: result = in_data.cmd.operand + operand_w'(pe_id + 1);
            op_invert: result = ~in_data.cmd.operand;
            op_shift:  result = {in_data.cmd.operand[operand_w-2:0], 1'b0};
            default:   result = in_data.cmd.operand;
        endcase
    end

    // result always heads for egress as a plain pass word
    always_comb begin
        next_word.cmd.op = op_pass;
        next_word.cmd.next_dest = field_w'(dest_egress);
        next_word.cmd.operand = result;
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            out_data <= next_word;
            out_dest <= in_data.cmd.next_dest[dest_w-1:0];
        end
    end

endmodule

//--- design/pe_switch_top.sv
`timescale 1ns/1ps

module pe_switch_top import pe_switch_pkg::*; (
    input  logic              CLK,
    input  logic              RST_N,

    input  logic              in_valid,
    output logic              in_ready,
    input  flit_t             in_data,
    input  logic [dest_w-1:0] in_dest,

    output logic              out_valid,
    input  logic              out_ready,
    output logic [data_w-1:0] out_data
);

    logic [n_pe-1:0]             pe_in_valid;
    logic [n_pe-1:0]             pe_in_ready;
    flit_t [n_pe-1:0]            pe_in_data;

    logic [n_pe-1:0]             pe_out_valid;
    logic [n_pe-1:0]             pe_out_ready;
    flit_t [n_pe-1:0]            pe_out_data;
    logic [n_pe-1:0][dest_w-1:0] pe_out_dest;

    pe_crossbar pe_crossbar_inst (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .in_dest      (in_dest),
        .pe_in_valid  (pe_in_valid),
        .pe_in_ready  (pe_in_ready),
        .pe_in_data   (pe_in_data),
        .pe_out_valid (pe_out_valid),
        .pe_out_ready (pe_out_ready),
        .pe_out_data  (pe_out_data),
        .pe_out_dest  (pe_out_dest),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

    // pe k sits on crossbar source k+1 and destination k
    for (genvar g = 0; g < n_pe; g++) begin : g_pe
        pe_core #(
            .pe_id (g)
        ) pe_core_inst (
            .CLK       (CLK),
            .RST_N     (RST_N),
            .in_valid  (pe_in_valid[g]),
            .in_ready  (pe_in_ready[g]),
            .in_data   (pe_in_data[g]),
            .out_valid (pe_out_valid[g]),
            .out_ready (pe_out_ready[g]),
            .out_data  (pe_out_data[g]),
            .out_dest  (pe_out_dest[g])
        );
    end

endmodule

//--- verification/pe_switch_assert.sv
`timescale 1ns/1ps

module pe_switch_assert import pe_switch_pkg::*; (
    input logic                          CLK,
    input logic                          RST_N,
    input logic [n_src-1:0]              src_valid,
    input logic [n_src-1:0]              src_ready,
    input flit_t [n_src-1:0]             src_data,
    input logic [n_src-1:0][dest_w-1:0]  src_dest,
    input logic [dest_egress:0][n_src-1:0] grant,
    input logic                          out_valid
);

    for (genvar d = 0; d <= int'(dest_egress); d++) begin : g_grant
        grant_onehot: assert property (@(posedge CLK) disable iff (!RST_N)
            $onehot0(grant[d]))
            else $error("destination %0d granted more than one source", d);
    end

    for (genvar s = 0; s < n_src; s++) begin : g_src
        // a waiting source keeps its word
        hold_word: assert property (@(posedge CLK) disable iff (!RST_N)
            src_valid[s] && !src_ready[s] |=>
                src_valid[s] && $stable(src_data[s]) && $stable(src_dest[s]))
            else $error("source %0d changed its word before it was taken", s);
    end

    reset_clears: assert property (@(posedge CLK) !RST_N |=> !out_valid)
        else $error("out_valid high after a reset cycle");

endmodule

bind pe_crossbar pe_switch_assert pe_switch_assert_inst (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .src_valid (src_valid),
    .src_ready (src_ready),
    .src_data  (src_data),
    .src_dest  (src_dest),
    .grant     (grant),
    .out_valid (out_valid)
);

//--- verification/tb_pe_switch.sv
`timescale 1ns/1ps

module tb_pe_switch import pe_switch_pkg::*; ();

    localparam string cases_file = "verification/switch_cases.txt";

    // case kinds in the cases file
    localparam int kind_single = 0;
    localparam int kind_drop = 1;
    localparam int kind_burst = 2;
    localparam int kind_set = 3;

    localparam int accept_timeout = 200;
    localparam int out_timeout = 500;
    localparam int quiet_window = 10;
    localparam int drop_window = 12;

    logic              CLK;
    logic              RST_N;
    logic              in_valid;
    logic              in_ready;
    flit_t             in_data;
    logic [dest_w-1:0] in_dest;
    logic              out_valid;
    logic              out_ready;
    logic [data_w-1:0] out_data;

    logic              throttle;

    int                case_kind[$];
    flit_t             case_word[$];
    logic [dest_w-1:0] case_dest[$];
    flit_t             case_expect[$];

    // everything taken at egress since the last clear
    logic [data_w-1:0] got_q[$];

    pe_switch_top pe_switch_top_inst (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // egress back-pressure, random only while throttle is set
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            if (throttle) begin
                out_ready = ($urandom % 4) != 0;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // a word seen here is taken on the next rising edge
    always @(negedge CLK) begin
        if (RST_N && out_valid && out_ready) begin
            got_q.push_back(out_data);
        end
    end

    task automatic end_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got.raw !== exp.raw) begin
            $display("FAILED %s: expected %h, got %h", name, exp.raw, got.raw);
            end_with_failure();
        end
    endtask

    // egress stays idle for the whole window
    task automatic check_none(input int window);
        for (int i = 0; i < window; i++) begin
            @(negedge CLK);
            if (out_valid) begin
                $display("egress produced word %h where no word was expected", out_data);
                end_with_failure();
            end
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic load_cases();
        int                fd;
        int                n;
        int                kind;
        int                dest;
        logic [data_w-1:0] word;
        logic [data_w-1:0] exp_word;
        string             line;
        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            $display("could not open the cases file %s", cases_file);
            end_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %d %h", kind, word, dest, exp_word);
            if (n != 4) begin
                $display("malformed line in the cases file: %s", line);
                end_with_failure();
            end
            case_kind.push_back(kind);
            case_word.push_back(word);
            case_dest.push_back(dest_w'(dest));
            case_expect.push_back(exp_word);
        end
        $fclose(fd);
        if (case_kind.size() == 0) begin
            $display("the cases file holds no cases");
            end_with_failure();
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_word(input flit_t word, input logic [dest_w-1:0] dest);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_data = word;
        in_dest = dest;
        @(negedge CLK);
        while (!in_ready) begin
            waited++;
            if (waited > accept_timeout) begin
                $display("ingress did not accept word %h within %0d cycles",
                         word.raw, accept_timeout);
                end_with_failure();
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int count);
        int waited;
        waited = 0;
        while (got_q.size() < count) begin
            @(posedge CLK);
            #1;
            waited++;
            if (waited > out_timeout) begin
                $display("only %0d of %0d egress words arrived within %0d cycles",
                         got_q.size(), count, out_timeout);
                end_with_failure();
            end
        end
    endtask

    task automatic single_word(input int idx);
        got_q.delete();
        send_word(case_word[idx], case_dest[idx]);
        wait_outputs(1);
        check_flit($sformatf("out_data (case %0d)", idx), got_q[0], case_expect[idx]);
        check_none(quiet_window);
    endtask

    task automatic dropped_word(input int idx);
        got_q.delete();
        send_word(case_word[idx], case_dest[idx]);
        check_none(drop_window);
    endtask

    // burst compares in order, set compares sorted
    task automatic word_group(input int first, input int last, input logic ordered);
        logic [data_w-1:0] exp_q[$];
        logic [data_w-1:0] rcv_q[$];
        got_q.delete();
        throttle = ordered;
        for (int i = first; i <= last; i++) begin
            send_word(case_word[i], case_dest[i]);
            exp_q.push_back(case_expect[i].raw);
        end
        wait_outputs(exp_q.size());
        throttle = 1'b0;
        rcv_q = got_q;
        if (!ordered) begin
            exp_q.sort();
            rcv_q.sort();
        end
        for (int i = 0; i < exp_q.size(); i++) begin
            check_flit($sformatf("out_data[%0d] (cases %0d to %0d)", i, first, last),
                       rcv_q[i], exp_q[i]);
        end
        check_none(quiet_window);
    endtask

    initial begin
        int idx;
        int last;
        void'($urandom(32'h3a9a_0b0f));
        RST_N = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_dest = '0;
        throttle = 1'b0;
        load_cases();
        repeat (2) @(posedge CLK);
        #1;
        RST_N = 1'b1;

        idx = 0;
        while (idx < case_kind.size()) begin
            case (case_kind[idx])
                kind_single: begin
                    single_word(idx);
                    idx++;
                end
                kind_drop: begin
                    dropped_word(idx);
                    idx++;
                end
                kind_burst, kind_set: begin
                    last = idx;
                    while (last + 1 < case_kind.size() &&
                           case_kind[last + 1] == case_kind[idx]) begin
                        last++;
                    end
                    word_group(idx, last, case_kind[idx] == kind_burst);
                    idx = last + 1;
                end
                default: begin
                    $display("unknown case kind %0d on case %0d", case_kind[idx], idx);
                    end_with_failure();
                end
            endcase
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verification/switch_cases.txt
# columns: kind (dec), ingress word (hex), ingress dest (dec), expected egress word (hex)
# kinds: 0 single word, 1 dropped word, 2 ordered burst, 3 unordered set
0 deadbeef 4 deadbeef
0 12345678 4 12345678
0 04123456 0 04123456
0 14000010 1 04000012
0 2400f0f0 2 04ff0f0f
0 34812345 3 0402468a
0 14fffffe 3 04000002
0 1400000f 0 04000010
0 24000000 1 04ffffff
0 34400001 2 04800002
0 74abcdef 2 04abcdef
0 0c000005 1 04000005
# pe to pe chains, second pe passes the first result on
0 12000100 1 04000102
0 30000333 3 04000666
0 230f0f0f 0 04f0f0f0
1 cafef00d 5 00000000
1 11111111 6 00000000
1 22222222 7 00000000
1 06000001 0 00000000
2 b0000001 4 b0000001
2 b0000002 4 b0000002
2 b0000003 4 b0000003
2 b0000004 4 b0000004
2 b0000005 4 b0000005
2 b0000006 4 b0000006
2 b0000007 4 b0000007
2 b0000008 4 b0000008
3 14000020 0 04000021
3 14000020 1 04000022
3 14000020 2 04000023
3 14000020 3 04000024
3 24555555 2 04aaaaaa
3 face0001 4 face0001

//--- build.f
design/pe_switch_pkg.sv
design/dest_arbiter.sv
design/pe_crossbar.sv
design/pe_core.sv
design/pe_switch_top.sv
verification/pe_switch_assert.sv
verification/tb_pe_switch.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pe_switch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
